/* ex_isa_pkg.sv */
package ex_isa_pkg;

    // Data path widths
    localparam int reg_w      = 32;
    localparam int reg_addr_w = 5;
    localparam int shamt_w    = 5;    // Only the low bits of rs take part in a shift

    typedef logic [reg_w-1:0]      word_t;
    typedef logic [2*reg_w-1:0]    dword_t;   // Full product, HI in the upper half
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // Operation issued to the execute stage
    typedef enum logic [4:0] {
        OP_NOP,
        // Bitwise logic
        OP_OR,
        OP_AND,
        OP_NOR,
        OP_XOR,
        // Shifts, amount taken from reg1
        OP_SLL,
        OP_SRL,
        OP_SRA,
        // Adder based
        OP_ADD,     // Trapless, write dropped on overflow
        OP_ADDU,
        OP_SUB,     // Same overflow rule as ADD
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        // Leading bit counts
        OP_CLZ,
        OP_CLO,
        // Multiplies
        OP_MUL,     // Low word to the register file
        OP_MULT,
        OP_MULTU,
        // HI/LO moves
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

endpackage

/* ex_pipe_pkg.sv */
package ex_pipe_pkg;

    import ex_isa_pkg::*;

    // What writeback does with a finished record
    typedef enum logic [2:0] {
        RES_REG,     // wdata to the register file
        RES_HILO,    // Both HI and LO
        RES_HI,
        RES_LO,
        RES_MFHI,    // HI read at writeback time
        RES_MFLO
    } res_kind_e;

    // One issued operation
    typedef struct packed {
        alu_op_e   aluop;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
    } ex_req_t;

    // One finished operation
    typedef struct packed {
        res_kind_e kind;
        word_t     wdata;
        word_t     hi;
        word_t     lo;
        reg_addr_t wd;
        logic      wreg;    // Already low after an ADD/SUB overflow
    } ex_res_t;

endpackage

/* ex_alu.sv */
`timescale 1ns/1ps

module ex_alu import ex_isa_pkg::*, ex_pipe_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    issue_i,
    input  ex_req_t req_i,
    output logic    push_o,
    output ex_res_t res_o
);

    localparam int CNT_W = $clog2(reg_w) + 1;    // Holds 0 to reg_w

    alu_op_e            op;
    word_t              op1;
    word_t              op2;
    logic [shamt_w-1:0] sh;
    word_t              logic_res;
    word_t              shift_res;
    logic               is_sub;
    word_t              op2_mux;
    word_t              sum;
    logic               ov_sum;
    logic               lt_res;
    word_t              cnt_src;
    logic [CNT_W-1:0]   lead_cnt;
    logic               mul_signed;
    word_t              mag1;
    word_t              mag2;
    dword_t             prod_mag;
    dword_t             product;
    ex_res_t            res_next;

    assign op  = req_i.aluop;
    assign op1 = req_i.reg1;
    assign op2 = req_i.reg2;
    assign sh  = op1[shamt_w-1:0];

    always_comb begin
        case (op)
            OP_OR:   logic_res = op1 | op2;
            OP_AND:  logic_res = op1 & op2;
            OP_NOR:  logic_res = ~(op1 | op2);
            OP_XOR:  logic_res = op1 ^ op2;
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (op)
            OP_SLL:  shift_res = op2 << sh;
            OP_SRL:  shift_res = op2 >> sh;
            // Sign bits shifted in from the top, zero shift leaves no fill
            OP_SRA:  shift_res = ({reg_w{op2[reg_w-1]}} << (CNT_W'(reg_w) - CNT_W'(sh)))
                                 | (op2 >> sh);
            default: shift_res = '0;
        endcase
    end

    // One adder for add, subtract and signed compare
    assign is_sub  = (op == OP_SUB) || (op == OP_SUBU) || (op == OP_SLT);
    assign op2_mux = is_sub ? (~op2 + 1'b1) : op2;
    assign sum     = op1 + op2_mux;

    // Operands of equal effective sign giving a result of the other sign
    assign ov_sum = (op1[reg_w-1] == (op2[reg_w-1] ^ is_sub))
                    && (sum[reg_w-1] != op1[reg_w-1]);

    assign lt_res = (op == OP_SLT) ?
                    ((op1[reg_w-1] && !op2[reg_w-1])
                     || ((op1[reg_w-1] == op2[reg_w-1]) && sum[reg_w-1])) :
                    (op1 < op2);

    // CLO counts zeros of the inverted word
    assign cnt_src = (op == OP_CLO) ? ~op1 : op1;

    always_comb begin
        logic found;
        found    = 1'b0;
        lead_cnt = '0;
        for (int i = reg_w - 1; i >= 0; i--) begin
            if (cnt_src[i]) begin
                found = 1'b1;
            end else if (!found) begin
                lead_cnt = lead_cnt + 1'b1;
            end
        end
    end

    // Multiply magnitudes, then restore the sign
    assign mul_signed = (op == OP_MUL) || (op == OP_MULT);
    assign mag1       = (mul_signed && op1[reg_w-1]) ? (~op1 + 1'b1) : op1;
    assign mag2       = (mul_signed && op2[reg_w-1]) ? (~op2 + 1'b1) : op2;
    assign prod_mag   = {{reg_w{1'b0}}, mag1} * {{reg_w{1'b0}}, mag2};
    assign product    = (mul_signed && (op1[reg_w-1] ^ op2[reg_w-1])) ?
                        (~prod_mag + 1'b1) : prod_mag;

    always_comb begin
        res_next.kind  = RES_REG;
        res_next.wdata = '0;
        res_next.hi    = '0;
        res_next.lo    = '0;
        res_next.wd    = req_i.wd;
        res_next.wreg  = req_i.wreg;
        case (op)
            OP_OR, OP_AND, OP_NOR, OP_XOR: res_next.wdata = logic_res;
            OP_SLL, OP_SRL, OP_SRA:        res_next.wdata = shift_res;
            OP_ADD, OP_SUB: begin
                res_next.wdata = sum;
                if (ov_sum) begin
                    res_next.wreg = 1'b0;    // Overflow drops the write
                end
            end
            OP_ADDU, OP_SUBU: res_next.wdata = sum;
            OP_SLT, OP_SLTU:  res_next.wdata = word_t'(lt_res);
            OP_CLZ, OP_CLO:   res_next.wdata = word_t'(lead_cnt);
            OP_MUL:           res_next.wdata = product[reg_w-1:0];
            OP_MULT, OP_MULTU: begin
                res_next.kind = RES_HILO;
                res_next.hi   = product[2*reg_w-1:reg_w];
                res_next.lo   = product[reg_w-1:0];
                res_next.wreg = 1'b0;
            end
            OP_MFHI: res_next.kind = RES_MFHI;    // Value filled in at writeback
            OP_MFLO: res_next.kind = RES_MFLO;
            OP_MTHI: begin
                res_next.kind = RES_HI;
                res_next.hi   = op1;
                res_next.wreg = 1'b0;
            end
            OP_MTLO: begin
                res_next.kind = RES_LO;
                res_next.lo   = op1;
                res_next.wreg = 1'b0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            push_o <= 1'b0;
        end else begin
            push_o <= issue_i;    // One push per issue
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            res_o <= res_next;
        end
    end

endmodule

/* ex_result_fifo.sv */
`timescale 1ns/1ps

module ex_result_fifo import ex_pipe_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    push_i,
    input  ex_res_t res_i,
    input  logic    pop_i,
    output ex_res_t head_o,
    output logic    nonempty_o,
    output logic    full_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    ex_res_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wrap also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o     = (count == CNT_W'(FIFO_DEPTH));
    assign nonempty_o = (count != '0);
    assign do_pop     = pop_i && nonempty_o;
    assign do_push    = push_i && (!full_o || do_pop);    // Push into a full queue is lost
    assign head_o     = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= res_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;    // Both or neither
            endcase
        end
    end

endmodule

/* ex_writeback.sv */
`timescale 1ns/1ps

module ex_writeback import ex_isa_pkg::*, ex_pipe_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      nonempty_i,
    input  logic      stall_i,
    input  ex_res_t   head_i,
    output logic      pop_o,
    output logic      wb_valid_o,
    output logic      wb_wreg_o,
    output reg_addr_t wb_wd_o,
    output word_t     wb_wdata_o,
    output word_t     hi_o,
    output word_t     lo_o
);

    word_t wdata_sel;

    assign pop_o = nonempty_i && !stall_i;

    // Moves from HI/LO see every earlier write, records leave in order
    always_comb begin
        case (head_i.kind)
            RES_MFHI: wdata_sel = hi_o;
            RES_MFLO: wdata_sel = lo_o;
            default:  wdata_sel = head_i.wdata;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_wreg_o  <= 1'b0;
            hi_o       <= '0;
            lo_o       <= '0;
        end else begin
            wb_valid_o <= pop_o;
            wb_wreg_o  <= pop_o && head_i.wreg;    // Only with a valid record
            if (pop_o) begin
                case (head_i.kind)
                    RES_HILO: begin
                        hi_o <= head_i.hi;
                        lo_o <= head_i.lo;
                    end
                    RES_HI:  hi_o <= head_i.hi;
                    RES_LO:  lo_o <= head_i.lo;
                    default: ;
                endcase
            end
        end
    end

    // Write address and data
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            wb_wd_o    <= head_i.wd;
            wb_wdata_o <= wdata_sel;
        end
    end

endmodule

/* ex_unit.sv */
`timescale 1ns/1ps

module ex_unit import ex_isa_pkg::*, ex_pipe_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      issue_i,
    input  ex_req_t   req_i,
    input  logic      stall_i,
    output logic      stallreq_o,
    output logic      wb_valid_o,
    output logic      wb_wreg_o,
    output reg_addr_t wb_wd_o,
    output word_t     wb_wdata_o,
    output word_t     hi_o,
    output word_t     lo_o
);

    logic    alu_push;
    ex_res_t alu_res;
    ex_res_t fifo_head;
    logic    fifo_nonempty;
    logic    wb_pop;

    // Producer
    ex_alu u_alu (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .issue_i (issue_i),
        .req_i   (req_i),
        .push_o  (alu_push),
        .res_o   (alu_res)
    );

    ex_result_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .push_i     (alu_push),
        .res_i      (alu_res),
        .pop_i      (wb_pop),
        .head_o     (fifo_head),
        .nonempty_o (fifo_nonempty),
        .full_o     (stallreq_o)    // Queue full stalls issue
    );

    // Consumer, owns HI and LO
    ex_writeback u_wb (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .nonempty_i (fifo_nonempty),
        .stall_i    (stall_i),
        .head_i     (fifo_head),
        .pop_o      (wb_pop),
        .wb_valid_o (wb_valid_o),
        .wb_wreg_o  (wb_wreg_o),
        .wb_wd_o    (wb_wd_o),
        .wb_wdata_o (wb_wdata_o),
        .hi_o       (hi_o),
        .lo_o       (lo_o)
    );

endmodule

/* ex_unit_properties.sv */
`timescale 1ns/1ps

module ex_unit_properties import ex_isa_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input logic  clk_i,
    input logic  rst_i,
    input logic  issue_i,
    input logic  stall_i,
    input logic  stallreq_i,
    input logic  push_i,
    input logic  pop_i,
    input logic  nonempty_i,
    input logic  wb_valid_i,
    input logic  wb_wreg_i,
    input word_t hi_i,
    input word_t lo_i
);

    localparam int OCC_W = $clog2(FIFO_DEPTH + 1);

    logic [OCC_W-1:0] occupancy;    // Shadow of the queue fill
    logic             occ_pop;
    logic             occ_push;
    int               fail_count = 0;

    assign occ_pop  = pop_i && (occupancy != '0);
    assign occ_push = push_i && ((occupancy != OCC_W'(FIFO_DEPTH)) || occ_pop);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            occupancy <= '0;
        end else if (occ_push && !occ_pop) begin
            occupancy <= occupancy + 1'b1;
        end else if (occ_pop && !occ_push) begin
            occupancy <= occupancy - 1'b1;
        end
    end

    a_reset_state: assert property (@(posedge clk_i)
        rst_i |=> !wb_valid_i && !wb_wreg_i && !stallreq_i && hi_i == '0 && lo_i == '0)
        else begin
            fail_count++;
            $error("Outputs not cleared by reset");
        end

    a_full_level: assert property (@(posedge clk_i) disable iff (rst_i)
        stallreq_i == (occupancy == OCC_W'(FIFO_DEPTH)))
        else begin
            fail_count++;
            $error("stallreq_o does not match a full queue");
        end

    a_issue_not_full: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_i |-> !stallreq_i)
        else begin
            fail_count++;
            $error("Issue strobe while stallreq_o is high");
        end

    a_no_drop: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i && stallreq_i |-> pop_i)
        else begin
            fail_count++;
            $error("Result pushed into a full queue");
        end

    a_stall_holds: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> !wb_valid_i)
        else begin
            fail_count++;
            $error("Writeback while stalled");
        end

    // Lone issue into an empty pipe with no stall at the pop edge
    a_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_i && !nonempty_i && !push_i ##2 !stall_i |=> wb_valid_i)
        else begin
            fail_count++;
            $error("Lone issue not written back after 3 cycles");
        end

endmodule

bind ex_unit ex_unit_properties #(
    .FIFO_DEPTH (FIFO_DEPTH)
) u_props (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .issue_i    (issue_i),
    .stall_i    (stall_i),
    .stallreq_i (stallreq_o),
    .push_i     (alu_push),
    .pop_i      (wb_pop),
    .nonempty_i (fifo_nonempty),
    .wb_valid_i (wb_valid_o),
    .wb_wreg_i  (wb_wreg_o),
    .hi_i       (hi_o),
    .lo_i       (lo_o)
);

/* tb_ex_unit.sv */
`timescale 1ns/1ps

module tb_ex_unit import ex_isa_pkg::*, ex_pipe_pkg::*; ();

    localparam int FIFO_DEPTH = 4;
    localparam int RANDOM_OPS = 300;
    localparam int WAIT_LIMIT = 200;    // Cycles per wait loop

    // One expected writeback record
    typedef struct packed {
        logic      wreg;
        logic      chk_data;    // Low where wdata carries nothing
        reg_addr_t wd;
        word_t     wdata;
        word_t     hi;
        word_t     lo;
    } expect_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      issue;
    ex_req_t   req;
    logic      stall;
    logic      stallreq;
    logic      wb_valid;
    logic      wb_wreg;
    reg_addr_t wb_wd;
    word_t     wb_wdata;
    word_t     hi;
    word_t     lo;

    expect_t exp_q[$];
    expect_t cur;
    word_t   model_hi;
    word_t   model_lo;
    logic    stall_random;
    int      seed;
    int      errors;
    int      timeouts;
    int      checks;
    int      issued;
    int      retired;

    ex_unit #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk_i      (clk),
        .rst_i      (rst),
        .issue_i    (issue),
        .req_i      (req),
        .stall_i    (stall),
        .stallreq_o (stallreq),
        .wb_valid_o (wb_valid),
        .wb_wreg_o  (wb_wreg),
        .wb_wd_o    (wb_wd),
        .wb_wdata_o (wb_wdata),
        .hi_o       (hi),
        .lo_o       (lo)
    );

    always #50 clk = ~clk;

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        errors++;
        $display("ERR %0t ns %s expected %h actual %h", $time, name, expected, actual);
    endtask

    function automatic word_t lead_count(input word_t w, input logic bit_val);
        int n;
        n = 0;
        while (n < reg_w && w[reg_w-1-n] == bit_val) begin
            n++;
        end
        return word_t'(n);
    endfunction

    function automatic word_t pick_operand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return 32'h7fff_ffff;
            3'd1:    return 32'h8000_0000;
            3'd2:    return 32'hffff_ffff;
            3'd3:    return 32'h0000_0000;
            default: return $random(seed);
        endcase
    endfunction

    function automatic alu_op_e random_op();
        logic [31:0] r;
        r = $random(seed);
        return alu_op_e'(5'(r % 32'd22 + 32'd1));    // OP_OR up to OP_MTLO
    endfunction

    // Reference result, HI and LO follow issue order
    task automatic model_op(input alu_op_e op, input word_t a, input word_t b,
                            input reg_addr_t wd, input logic wreg);
        expect_t     e;
        logic [32:0] wide;
        dword_t      prod;
        e.wreg     = wreg;
        e.chk_data = 1'b1;
        e.wd       = wd;
        e.wdata    = '0;
        prod = $signed({{reg_w{a[reg_w-1]}}, a}) * $signed({{reg_w{b[reg_w-1]}}, b});
        case (op)
            OP_OR:   e.wdata = a | b;
            OP_AND:  e.wdata = a & b;
            OP_NOR:  e.wdata = ~(a | b);
            OP_XOR:  e.wdata = a ^ b;
            OP_SLL:  e.wdata = b << a[shamt_w-1:0];
            OP_SRL:  e.wdata = b >> a[shamt_w-1:0];
            OP_SRA:  e.wdata = $signed(b) >>> a[shamt_w-1:0];
            OP_ADD, OP_SUB: begin
                wide = (op == OP_ADD) ? ({a[reg_w-1], a} + {b[reg_w-1], b}) :
                                        ({a[reg_w-1], a} - {b[reg_w-1], b});
                e.wdata = wide[reg_w-1:0];
                if (wide[reg_w] != wide[reg_w-1]) begin
                    e.wreg = 1'b0;    // Signed overflow
                end
            end
            OP_ADDU: e.wdata = a + b;
            OP_SUBU: e.wdata = a - b;
            OP_SLT:  e.wdata = word_t'($signed(a) < $signed(b));
            OP_SLTU: e.wdata = word_t'(a < b);
            OP_CLZ:  e.wdata = lead_count(a, 1'b0);
            OP_CLO:  e.wdata = lead_count(a, 1'b1);
            OP_MUL:  e.wdata = prod[reg_w-1:0];
            OP_MULT, OP_MULTU: begin
                if (op == OP_MULTU) begin
                    prod = {{reg_w{1'b0}}, a} * {{reg_w{1'b0}}, b};
                end
                {model_hi, model_lo} = prod;
                e.wreg     = 1'b0;
                e.chk_data = 1'b0;
            end
            OP_MFHI: e.wdata = model_hi;
            OP_MFLO: e.wdata = model_lo;
            OP_MTHI, OP_MTLO: begin
                if (op == OP_MTHI) begin
                    model_hi = a;
                end else begin
                    model_lo = a;
                end
                e.wreg     = 1'b0;
                e.chk_data = 1'b0;
            end
            default: e.chk_data = 1'b0;
        endcase
        e.hi = model_hi;
        e.lo = model_lo;
        exp_q.push_back(e);
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #5;
        if (stall_random) begin
            stall = (($random(seed) & 3) == 0);
        end
    endtask

    task automatic issue_op(input alu_op_e op, input word_t a, input word_t b);
        int        waited;
        reg_addr_t wd;
        logic      wreg;
        waited = 0;
        // Never more in flight than the queue can hold
        while (stallreq || (issued - retired) >= FIFO_DEPTH) begin
            if (waited == WAIT_LIMIT) begin
                timeouts++;
                $display("Timeout at %0t: no room to issue a new operation", $time);
                return;
            end
            waited++;
            step_cycle();
        end
        wd   = reg_addr_t'($random(seed));
        wreg = (($random(seed) & 7) != 0);
        req  = '{aluop: op, reg1: a, reg2: b, wd: wd, wreg: wreg};
        issue = 1'b1;
        model_op(op, a, b, wd, wreg);
        issued++;
        step_cycle();
        issue = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (issued != retired) begin
            if (waited == WAIT_LIMIT) begin
                timeouts++;
                $display("Timeout at %0t: %0d results never came back", $time, issued - retired);
                return;
            end
            waited++;
            step_cycle();
        end
    endtask

    task automatic wait_stallreq();
        int waited;
        waited = 0;
        while (!stallreq) begin
            if (waited == WAIT_LIMIT) begin
                timeouts++;
                $display("Timeout at %0t: full queue never raised stallreq_o", $time);
                return;
            end
            waited++;
            step_cycle();
        end
    endtask

    task automatic check_reset_state();
        assert (!wb_valid) else report_mismatch("wb_valid_o", '0, word_t'(wb_valid));
        assert (!wb_wreg) else report_mismatch("wb_wreg_o", '0, word_t'(wb_wreg));
        assert (!stallreq) else report_mismatch("stallreq_o", '0, word_t'(stallreq));
        assert (hi == '0) else report_mismatch("hi_o", '0, hi);
        assert (lo == '0) else report_mismatch("lo_o", '0, lo);
    endtask

    // Outputs settle after the rising edge, compare at the falling edge
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Writeback at %0t with no issued operation left to match", $time);
            end else begin
                cur = exp_q.pop_front();
                retired++;
                checks++;
                assert (wb_wreg == cur.wreg)
                    else report_mismatch("wb_wreg_o", word_t'(cur.wreg), word_t'(wb_wreg));
                assert (wb_wd == cur.wd)
                    else report_mismatch("wb_wd_o", word_t'(cur.wd), word_t'(wb_wd));
                if (cur.chk_data) begin
                    assert (wb_wdata == cur.wdata)
                        else report_mismatch("wb_wdata_o", cur.wdata, wb_wdata);
                end
                assert (hi == cur.hi) else report_mismatch("hi_o", cur.hi, hi);
                assert (lo == cur.lo) else report_mismatch("lo_o", cur.lo, lo);
            end
        end
    end

    initial begin
        rst          = 1'b1;
        issue        = 1'b0;
        req          = '0;
        stall        = 1'b0;
        stall_random = 1'b0;
        seed         = 32'hb517_ffbb;
        model_hi     = '0;
        model_lo     = '0;
        errors       = 0;
        timeouts     = 0;
        checks       = 0;
        issued       = 0;
        retired      = 0;
        repeat (3) @(posedge clk);
        #5;
        check_reset_state();
        rst = 1'b0;
        step_cycle();
        check_reset_state();

        // Corner values, shift amount and count source are reg1
        issue_op(OP_CLZ, 32'h0000_0000, 32'h0);
        issue_op(OP_CLO, 32'hffff_ffff, 32'h0);
        issue_op(OP_SRA, 32'd4, 32'h8000_00f0);
        issue_op(OP_ADD, 32'h7fff_ffff, 32'h1);    // Overflow
        issue_op(OP_SUB, 32'h8000_0000, 32'h1);    // Overflow
        issue_op(OP_ADDU, 32'hffff_ffff, 32'h2);
        issue_op(OP_SLT, 32'h8000_0000, 32'h1);
        issue_op(OP_SLTU, 32'h8000_0000, 32'h1);
        issue_op(OP_MULT, 32'hffff_ffff, 32'h7fff_ffff);
        issue_op(OP_MFHI, 32'h0, 32'h0);
        issue_op(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
        issue_op(OP_MTHI, 32'h1234_5678, 32'h0);
        issue_op(OP_MFLO, 32'h0, 32'h0);
        issue_op(OP_MUL, 32'h8000_0000, 32'hffff_ffff);
        wait_drain();

        issue_op(OP_ADDU, 32'h1, 32'h2);    // Lone issue for the latency property
        wait_drain();

        // Fill the queue under stall, then let it drain
        stall = 1'b1;
        repeat (FIFO_DEPTH) issue_op(random_op(), pick_operand(), pick_operand());
        wait_stallreq();
        repeat (5) step_cycle();
        stall = 1'b0;
        wait_drain();

        stall_random = 1'b1;
        repeat (RANDOM_OPS) issue_op(random_op(), pick_operand(), pick_operand());
        stall_random = 1'b0;
        stall        = 1'b0;
        wait_drain();

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d issued operations were never written back", exp_q.size());
        end
        if (uut.u_props.fail_count != 0) begin
            errors += uut.u_props.fail_count;
            $display("%0d concurrent assertion failures", uut.u_props.fail_count);
        end
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* ex_unit.f */
ex_isa_pkg.sv
ex_pipe_pkg.sv
ex_alu.sv
ex_result_fifo.sv
ex_writeback.sv
ex_unit.sv
ex_unit_properties.sv
tb_ex_unit.sv

/* Bender.yml */
package:
  name: ex_unit

sources:
  - ex_isa_pkg.sv
  - ex_pipe_pkg.sv
  - ex_alu.sv
  - ex_result_fifo.sv
  - ex_writeback.sv
  - ex_unit.sv
  - target: test
    files:
      - ex_unit_properties.sv
      - tb_ex_unit.sv
